// File: hw/fetch_if.sv
////////////////////////////////////////////////////////////
// valid/ready channel from the fetch unit to IF-ID
// payload holds while valid is high unless a PC set flushes it
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface fetch_if import if_pkg::*; ();

  logic  valid;
  // ready is driven by the IF-ID side
  logic  ready;
  addr_t rdata;
  // PC of the word in rdata
  addr_t addr;
  // bus error seen on this fetch
  logic  err;

  modport src (output valid, output rdata, output addr, output err, input ready);

  modport dst (input valid, input rdata, input addr, input err, output ready);

endinterface

// File: hw/fetch_unit.sv
////////////////////////////////////////////////////////////
// one request in flight at a time, no prefetch buffering
// a PC set marks any outstanding response as stale
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_unit import if_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req_i,
  input  logic  pc_set_i,
  input  addr_t fetch_addr_i,
  // instruction bus
  output logic  instr_req_o,
  output addr_t instr_addr_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  input  addr_t instr_rdata_i,
  input  logic  instr_err_i,
  output logic  busy_o,
  fetch_if.src  out_if
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT,
    S_HOLD
  } state_e;

  state_e state_q, state_d;
  state_e fetch_next;
  // PC of the word being fetched or held
  addr_t  addr_q, addr_d;
  // address on the bus, frozen while requesting
  addr_t  bus_addr_q;
  addr_t  rdata_q;
  logic   err_q;
  logic   discard_q, discard_d;
  logic   fetch_en_q;
  logic   rsp_take;
  logic   xfer;

  assign xfer       = out_if.valid & out_if.ready;
  assign fetch_next = req_i ? S_REQ : S_IDLE;

  // response belongs to addr_q and survives only without a PC set
  assign rsp_take = (state_q == S_WAIT) & instr_rvalid_i & ~discard_q & ~pc_set_i;

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    addr_d    = pc_set_i ? fetch_addr_i : addr_q;
    discard_d = discard_q;
    unique case (state_q)
      S_IDLE: begin
        // nothing to fetch until a first PC set
        if (req_i && (fetch_en_q || pc_set_i)) begin
          state_d = S_REQ;
        end
      end
      S_REQ: begin
        // the pending request can't be withdrawn
        if (pc_set_i) begin
          discard_d = 1'b1;
        end
        if (instr_gnt_i) begin
          state_d = S_WAIT;
        end
      end
      S_WAIT: begin
        if (instr_rvalid_i) begin
          discard_d = 1'b0;
          state_d   = rsp_take ? S_HOLD : fetch_next;
        end else if (pc_set_i) begin
          discard_d = 1'b1;
        end
      end
      S_HOLD: begin
        if (pc_set_i) begin
          state_d = fetch_next;
        end else if (xfer) begin
          // sequential step after an accepted word
          addr_d  = addr_q + INSTR_STEP;
          state_d = fetch_next;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= S_IDLE;
      discard_q  <= 1'b0;
      fetch_en_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      discard_q  <= discard_d;
      fetch_en_q <= fetch_en_q | pc_set_i;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    // bus address only moves while no request is up
    if (state_q != S_REQ) begin
      bus_addr_q <= addr_d;
    end
    if (rsp_take) begin
      rdata_q <= instr_rdata_i;
      err_q   <= instr_err_i;
    end
  end

  assign instr_req_o  = (state_q == S_REQ);
  assign instr_addr_o = bus_addr_q;
  assign busy_o       = (state_q == S_REQ) | (state_q == S_WAIT);

  // held word goes out to IF-ID
  assign out_if.valid = (state_q == S_HOLD);
  assign out_if.rdata = rdata_q;
  assign out_if.addr  = addr_q;
  assign out_if.err   = err_q;

endmodule

// File: hw/if_id_reg.sv
////////////////////////////////////////////////////////////
// loads on a fetch_if transfer, one cycle of latency
// valid stays up until ID clears it
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module if_id_reg import if_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  pc_set_i,
  input  logic  instr_valid_clear_i,
  input  logic  id_in_ready_i,
  fetch_if.dst  in_if,
  output logic  instr_valid_id_o,
  output logic  instr_new_id_o,
  output addr_t instr_rdata_id_o,
  output logic  instr_fetch_err_o,
  output addr_t pc_id_o,
  output logic  pc_mismatch_alert_o
);

  logic  xfer;
  logic  valid_q, valid_d;
  logic  new_q;
  logic  seq_q, seq_d;
  addr_t pc_incr;

  // a word arriving with a PC set is squashed, so no transfer then
  assign in_if.ready = id_in_ready_i & ~pc_set_i;
  assign xfer        = in_if.valid & in_if.ready;

  // set by a transfer, held until explicitly cleared
  assign valid_d = xfer | (valid_q & ~instr_valid_clear_i);

  ////////////////////////////////////////////////////////////
  // flags
  ////////////////////////////////////////////////////////////

  // sequential flow ends at any PC set
  assign seq_d = (seq_q | xfer) & ~pc_set_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
      seq_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= xfer;
      seq_q   <= seq_d;
    end
  end

  // pipeline register, frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      instr_rdata_id_o  <= in_if.rdata;
      instr_fetch_err_o <= in_if.err;
      pc_id_o           <= in_if.addr;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  ////////////////////////////////////////////////////////////
  // PC increment check
  ////////////////////////////////////////////////////////////

  // every word is 32 bits so the step is always 4
  assign pc_incr = pc_id_o + INSTR_STEP;

  assign pc_mismatch_alert_o = seq_q & in_if.valid & (in_if.addr != pc_incr);

endmodule

// File: hw/if_pkg.sv
////////////////////////////////////////////////////////////
// every instruction is 32 bits wide, with no compressed ISA
// boot address and mtvec are aligned to VEC_ALIGN_BITS
////////////////////////////////////////////////////////////

package if_pkg;

  // datapath width for PCs and instruction words
  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] addr_t;

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // trap target used when the PC source is PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // picks one of 32 vectored slots
  typedef logic [4:0] irq_id_t;

  // fixed debug module entry points
  localparam addr_t DM_HALT_ADDR = 32'h1A11_0800;
  localparam addr_t DM_EXC_ADDR  = 32'h1A11_0808;

  // first instruction sits at this offset in the boot block
  localparam logic [7:0] BOOT_OFFSET = 8'h80;

  // low bits ignored in boot_addr and mtvec
  localparam int unsigned VEC_ALIGN_BITS = 8;

  localparam addr_t INSTR_STEP = 32'd4;

endpackage

// File: hw/if_stage.sv
////////////////////////////////////////////////////////////
// instruction fetch stage top, 32-bit words only
// fetching starts after a pc_set_i with req_i high
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module if_stage import if_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  addr_t       boot_addr_i,
  input  logic        req_i,
  // instruction bus
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  addr_t       instr_rdata_i,
  input  logic        instr_err_i,
  // towards ID
  output logic        instr_valid_id_o,
  output logic        instr_new_id_o,
  output addr_t       instr_rdata_id_o,
  output logic        instr_fetch_err_o,
  output addr_t       pc_if_o,
  output addr_t       pc_id_o,
  // control from ID
  input  logic        instr_valid_clear_i,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_sel_i,
  input  exc_pc_sel_e exc_pc_sel_i,
  input  irq_id_t     exc_cause_i,
  input  addr_t       branch_target_i,
  // csr values
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  output logic        csr_mtvec_init_o,
  input  logic        id_in_ready_i,
  output logic        pc_mismatch_alert_o,
  output logic        if_busy_o
);

  addr_t fetch_addr_n;

  fetch_if fetch_bus ();

  pc_select i_pc_select (
    .boot_addr_i      (boot_addr_i),
    .pc_sel_i         (pc_sel_i),
    .exc_pc_sel_i     (exc_pc_sel_i),
    .irq_id_i         (exc_cause_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .pc_set_i         (pc_set_i),
    .fetch_addr_o     (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  fetch_unit i_fetch_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .fetch_addr_i   (fetch_addr_n),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .busy_o         (if_busy_o),
    .out_if         (fetch_bus.src)
  );

  if_id_reg i_if_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .id_in_ready_i       (id_in_ready_i),
    .in_if               (fetch_bus.dst),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  // PC of the word offered by the fetch unit
  assign pc_if_o = fetch_bus.addr;

endmodule

// File: hw/pc_select.sv
////////////////////////////////////////////////////////////
// purely combinational, fetch_addr_o is valid in the pc_set cycle
// low byte of boot_addr_i and csr_mtvec_i is ignored
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pc_select import if_pkg::*; (
  input  addr_t       boot_addr_i,
  input  pc_sel_e     pc_sel_i,
  input  exc_pc_sel_e exc_pc_sel_i,
  input  irq_id_t     irq_id_i,
  input  addr_t       branch_target_i,
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  input  logic        pc_set_i,
  output addr_t       fetch_addr_o,
  output logic        csr_mtvec_init_o
);

  addr_t exc_pc;
  addr_t boot_pc;

  // boot block base with the fixed entry offset
  assign boot_pc = {boot_addr_i[XLEN-1:VEC_ALIGN_BITS], BOOT_OFFSET};

  // trap vector, vectored irqs land at mtvec base + 4*id
  always_comb begin
    unique case (exc_pc_sel_i)
      EXC_PC_EXC:     exc_pc = {csr_mtvec_i[XLEN-1:VEC_ALIGN_BITS], 8'h00};
      EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[XLEN-1:VEC_ALIGN_BITS], 1'b0, irq_id_i, 2'b00};
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = {csr_mtvec_i[XLEN-1:VEC_ALIGN_BITS], 8'h00};
    endcase
  end

  // next fetch address
  always_comb begin
    unique case (pc_sel_i)
      PC_BOOT: fetch_addr_o = boot_pc;
      PC_JUMP: fetch_addr_o = branch_target_i;
      // trap handler entry
      PC_EXC:  fetch_addr_o = exc_pc;
      // return from trap
      PC_ERET: fetch_addr_o = csr_mepc_i;
      // return from debug mode
      PC_DRET: fetch_addr_o = csr_depc_i;
      default: fetch_addr_o = boot_pc;
    endcase
  end

  // csr file sets mtvec from boot_addr on the boot jump
  assign csr_mtvec_init_o = pc_set_i & (pc_sel_i == PC_BOOT);

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the IF stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_if_stage -o tb_if_stage
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

# keep going after assertion errors so the testbench gives its verdict
output=$(./obj_dir/tb_if_stage +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

// File: sim.f
hw/if_pkg.sv
hw/fetch_if.sv
hw/pc_select.sv
hw/fetch_unit.sv
hw/if_id_reg.sv
hw/if_stage.sv
testbench/if_stage_chk.sv
testbench/tb_if_stage.sv

// File: testbench/if_stage_chk.sv
////////////////////////////////////////////////////////////
// bus and IF-ID protocol properties bound into if_stage
// fail_cnt_o sums the failures of all properties
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module if_stage_chk import if_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  req_i,
  input addr_t addr_i,
  input logic  gnt_i,
  input logic  valid_id_i,
  input logic  valid_clear_i,
  input logic  pc_set_i,
  output int   fail_cnt_o
);

  int align_fails = 0;
  int hold_fails = 0;
  int valid_fails = 0;

  assign fail_cnt_o = align_fails + hold_fails + valid_fails;

  // fetches are whole words only
  req_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> (addr_i[1:0] == 2'b00))
    else begin
      align_fails = align_fails + 1;
      $error("instruction request on an unaligned address");
    end

  // no withdraw and no address change before grant
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && !gnt_i) |=> (req_i && $stable(addr_i)))
    else begin
      hold_fails = hold_fails + 1;
      $error("request or address changed before grant");
    end

  // valid in ID drops only on clear or PC set
  valid_kept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_id_i && !valid_clear_i && !pc_set_i) |=> valid_id_i)
    else begin
      valid_fails = valid_fails + 1;
      $error("instruction valid in ID fell without clear or PC set");
    end

endmodule

bind if_stage if_stage_chk i_chk (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .req_i         (instr_req_o),
  .addr_i        (instr_addr_o),
  .gnt_i         (instr_gnt_i),
  .valid_id_i    (instr_valid_id_o),
  .valid_clear_i (instr_valid_clear_i),
  .pc_set_i      (pc_set_i),
  .fail_cnt_o    ()
);

// File: testbench/tb_if_stage.sv
////////////////////////////////////////////////////////////
// memory model grants in 0..2 cycles and answers 1..3 later
// rdata is address ^ A5A5A5A5 and bus errors hit 0000F000..0000F0FF
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_if_stage import if_pkg::*; ();

  logic clk_i = 1'b0;
  logic rst_ni, req_i, pc_set_i, instr_valid_clear_i, id_in_ready_i;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic instr_valid_id_o, instr_new_id_o, instr_fetch_err_o;
  logic csr_mtvec_init_o, pc_mismatch_alert_o, if_busy_o;
  addr_t boot_addr_i, instr_addr_o, instr_rdata_i, instr_rdata_id_o, pc_if_o, pc_id_o;
  addr_t branch_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i;
  pc_sel_e pc_sel_i;
  exc_pc_sel_e exc_pc_sel_i;
  irq_id_t exc_cause_i;

  int seed = 32'h81ef;
  int value_errors = 0;
  int timeouts = 0;
  int new_count = 0;
  logic first_pending = 1'b0;
  // granted request whose response has not come back yet
  logic rsp_open = 1'b0;
  addr_t exp_pc, last_pc;
  // PC offered by IF in the previous cycle
  addr_t prev_pc_if;
  string test_name = "reset";

  if_stage i_dut (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic in_err_range(addr_t a);
    return (a >= 32'h0000_F000) && (a <= 32'h0000_F0FF);
  endfunction

  // expected fetch target from the address map
  function automatic addr_t exp_target(pc_sel_e sel, exc_pc_sel_e esel, irq_id_t irq);
    addr_t base;
    base = csr_mtvec_i & 32'hFFFF_FF00;
    case (sel)
      PC_BOOT: return (boot_addr_i & 32'hFFFF_FF00) + 32'h80;
      PC_JUMP: return branch_target_i;
      PC_ERET: return csr_mepc_i;
      PC_DRET: return csr_depc_i;
      default: begin
        case (esel)
          EXC_PC_IRQ:     return base + (32'(irq) << 2);
          EXC_PC_DBD:     return 32'h1A11_0800;
          EXC_PC_DBG_EXC: return 32'h1A11_0808;
          default:        return base;
        endcase
      end
    endcase
  endfunction

  task automatic log_mismatch(input string what, input addr_t exp, input addr_t act);
    value_errors++;
    $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
  endtask

  ////////////////////////////////////////////////////////////
  // instruction bus slave
  ////////////////////////////////////////////////////////////

  initial begin : memory_model
    int gnt_delay;
    int rsp_delay;
    logic rsp_pending;
    addr_t rsp_addr;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    instr_err_i = 1'b0;
    rsp_pending = 1'b0;
    rsp_delay = 0;
    rsp_addr = '0;
    gnt_delay = $unsigned($random(seed)) % 3;
    forever begin
      @(posedge clk_i);
      // latch the address of an accepted request for the response
      if (instr_req_o && instr_gnt_i) begin
        rsp_pending = 1'b1;
        rsp_addr = instr_addr_o;
        rsp_delay = $unsigned($random(seed)) % 3;
        gnt_delay = $unsigned($random(seed)) % 3;
      end
      #1;
      instr_rvalid_i = 1'b0;
      if (rsp_pending) begin
        if (rsp_delay == 0) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i = rsp_addr ^ 32'hA5A5_A5A5;
          instr_err_i = in_err_range(rsp_addr);
          rsp_pending = 1'b0;
        end else begin
          rsp_delay--;
        end
      end
      instr_gnt_i = 1'b0;
      if (instr_req_o) begin
        if (gnt_delay == 0) instr_gnt_i = 1'b1;
        else gnt_delay--;
      end
    end
  end

  // ID side drops ready for random stretches
  initial begin : id_model
    int stretch;
    id_in_ready_i = 1'b1;
    instr_valid_clear_i = 1'b0;
    stretch = 0;
    forever begin
      @(posedge clk_i);
      #1;
      if (stretch == 0) begin
        id_in_ready_i = ($unsigned($random(seed)) % 3) != 0;
        stretch = 1 + $unsigned($random(seed)) % 4;
      end
      stretch--;
      instr_valid_clear_i = ($unsigned($random(seed)) % 4) == 0;
    end
  end

  ////////////////////////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    addr_t want;
    if (rst_ni) begin
      assert (csr_mtvec_init_o == (pc_set_i && (pc_sel_i == PC_BOOT)))
        else log_mismatch("mtvec init", 32'(pc_set_i && (pc_sel_i == PC_BOOT)),
                          32'(csr_mtvec_init_o));
      assert (!pc_mismatch_alert_o) else log_mismatch("pc alert", 32'd0, 32'd1);
      // busy covers a request on the bus and the wait for its response
      assert (if_busy_o == (instr_req_o || rsp_open))
        else log_mismatch("busy", 32'(instr_req_o || rsp_open), 32'(if_busy_o));
      if (instr_new_id_o) begin
        assert (instr_rdata_id_o == (pc_id_o ^ 32'hA5A5_A5A5))
          else log_mismatch("rdata", pc_id_o ^ 32'hA5A5_A5A5, instr_rdata_id_o);
        assert (instr_fetch_err_o == in_err_range(pc_id_o))
          else log_mismatch("fetch err", 32'(in_err_range(pc_id_o)), 32'(instr_fetch_err_o));
        if (first_pending) begin
          want = exp_pc;
          first_pending = 1'b0;
        end else begin
          want = last_pc + 32'd4;
        end
        assert (pc_id_o == want) else log_mismatch("pc in ID", want, pc_id_o);
        // the word was offered by IF in the transfer cycle
        assert (prev_pc_if == want) else log_mismatch("pc in IF", want, prev_pc_if);
        last_pc = want;
        new_count++;
      end
      // a PC set starts a new stream after the word above
      if (pc_set_i) begin
        exp_pc = exp_target(pc_sel_i, exc_pc_sel_i, exc_cause_i);
        first_pending = 1'b1;
      end
      if (instr_rvalid_i) begin
        rsp_open = 1'b0;
      end
      if (instr_req_o && instr_gnt_i) begin
        rsp_open = 1'b1;
      end
    end
    prev_pc_if = pc_if_o;
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic set_pc(input string name, input pc_sel_e sel, input exc_pc_sel_e esel,
                        input irq_id_t irq);
    @(posedge clk_i);
    #1;
    test_name = name;
    pc_set_i = 1'b1;
    pc_sel_i = sel;
    exc_pc_sel_i = esel;
    exc_cause_i = irq;
    @(posedge clk_i);
    #1;
    pc_set_i = 1'b0;
  endtask

  task automatic wait_new(input int n);
    int goal;
    int cycles;
    goal = new_count + n;
    cycles = 0;
    while ((new_count < goal) && (cycles < 300)) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (new_count < goal) begin
      timeouts++;
      $display("%s timed out with %0d of %0d instructions", test_name, n - (goal - new_count), n);
    end
  endtask

  initial begin : main
    int total;
    logic [5:0] low_outs;
    rst_ni = 1'b0;
    req_i = 1'b0;
    pc_set_i = 1'b0;
    pc_sel_i = PC_BOOT;
    exc_pc_sel_i = EXC_PC_EXC;
    exc_cause_i = '0;
    boot_addr_i = 32'h0000_1234;
    branch_target_i = 32'h0000_F0F0;
    // low byte of mtvec must be ignored
    csr_mtvec_i = 32'h0000_2001;
    csr_mepc_i = 32'h0000_3000;
    csr_depc_i = 32'h0000_4004;
    repeat (3) @(posedge clk_i);
    #1;
    // outputs that reset holds low
    low_outs = {instr_req_o, instr_valid_id_o, instr_new_id_o, csr_mtvec_init_o,
                pc_mismatch_alert_o, if_busy_o};
    assert (low_outs == 6'b0) else log_mismatch("outputs in reset", 32'd0, 32'(low_outs));
    rst_ni = 1'b1;
    req_i = 1'b1;
    set_pc("boot", PC_BOOT, EXC_PC_EXC, 5'd0);
    wait_new(6);
    // runs across the end of the error window
    set_pc("jump", PC_JUMP, EXC_PC_EXC, 5'd0);
    wait_new(8);
    set_pc("exception", PC_EXC, EXC_PC_EXC, 5'd0);
    wait_new(4);
    for (int id = 0; id < 32; id += 7) begin
      set_pc($sformatf("irq %0d", id), PC_EXC, EXC_PC_IRQ, irq_id_t'(id));
      wait_new(3);
    end
    set_pc("debug halt", PC_EXC, EXC_PC_DBD, 5'd0);
    wait_new(4);
    set_pc("debug exception", PC_EXC, EXC_PC_DBG_EXC, 5'd0);
    wait_new(4);
    set_pc("mret", PC_ERET, EXC_PC_EXC, 5'd0);
    wait_new(4);
    set_pc("dret", PC_DRET, EXC_PC_EXC, 5'd0);
    wait_new(4);
    // second set lands while the first fetch is in flight
    for (int i = 0; i < 6; i++) begin
      branch_target_i = 32'h0000_5000 + 32'(i) * 32'h100;
      set_pc("stale discard", PC_JUMP, EXC_PC_EXC, 5'd0);
      branch_target_i = 32'h0000_6000 + 32'(i) * 32'h100;
      set_pc("stale discard", PC_JUMP, EXC_PC_EXC, 5'd0);
      wait_new(5);
    end
    repeat (5) @(posedge clk_i);
    total = value_errors + timeouts + i_dut.i_chk.fail_cnt_o;
    $display("errors %0d value, %0d timeout, %0d assertion", value_errors, timeouts,
             i_dut.i_chk.fail_cnt_o);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
